/* tb.f */
verilog/ahb_sub_pkg.sv
verilog/ahb_if.sv
verilog/ahb_decoder.sv
verilog/ahb_mem_ctrl.sv
verilog/ahb_gpio_regs.sv
verilog/ahb_err_gen.sv
verilog/ahb_sub_top.sv
test/ahb_sub_tb.sv

/* test/ahb_sub_tb.sv */
// AHB subsystem testbench
`timescale 1ns/1ps

module ahb_sub_tb;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_LINES    = 64;
  localparam int GPIO_W       = 8;

  logic              clk;
  logic              i_arst_n;
  logic [31:0]       i_haddr;
  logic [1:0]        i_htrans;
  logic              i_hwrite;
  logic [31:0]       i_hwdata;
  logic [GPIO_W-1:0] i_gpio_porta;
  logic [31:0]       o_hrdata;
  logic              o_hready;
  logic              o_hresp;
  logic [GPIO_W-1:0] o_gpio_porta;

  logic              tr_write [MAX_LINES];
  logic [31:0]       tr_addr  [MAX_LINES];
  logic [31:0]       tr_data  [MAX_LINES];
  logic              tr_resp  [MAX_LINES];
  logic [GPIO_W-1:0] tr_gpio  [MAX_LINES];
  int                n_lines;
  logic              trace_loaded;
  int                err_cnt;
  int                check_cnt;

  // address slot and data slot of the master
  logic              a_valid;
  logic              d_valid;
  int                a_idx;
  int                d_idx;
  int                d_waits;
  int                next_line;
  int                gap_left;
  logic              seen_ready;
  logic              seen_resp;
  logic [31:0]       seen_rdata;
  logic              gpio_pend;
  logic [GPIO_W-1:0] gpio_exp;

  ahb_sub_top dut (
    .i_per_clk    (clk),
    .i_arst_n     (i_arst_n),
    .i_haddr      (i_haddr),
    .i_htrans     (i_htrans),
    .i_hwrite     (i_hwrite),
    .i_hwdata     (i_hwdata),
    .o_hrdata     (o_hrdata),
    .o_hready     (o_hready),
    .o_hresp      (o_hresp),
    .i_gpio_porta (i_gpio_porta),
    .o_gpio_porta (o_gpio_porta)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_trace;
    integer            fd;
    integer            rc;
    reg [8*96-1:0]     line_buf;
    reg [7:0]          op;
    logic [31:0]       addr_v;
    logic [31:0]       data_v;
    integer            resp_v;
    logic [GPIO_W-1:0] gpio_v;
    n_lines = 0;
    fd = $fopen("test/ahb_sub_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: trace file test/ahb_sub_trace.txt could not be opened");
      err_cnt++;
    end else begin
      while ($fgets(line_buf, fd) != 0) begin
        rc = $sscanf(line_buf, "%s %h %h %d %h", op, addr_v, data_v, resp_v, gpio_v);
        // comment lines never parse to a full R or W entry
        if (rc == 5 && (op == "R" || op == "W") && n_lines < MAX_LINES) begin
          tr_write[n_lines] = (op == "W");
          tr_addr[n_lines]  = addr_v;
          tr_data[n_lines]  = data_v;
          tr_resp[n_lines]  = resp_v[0];
          tr_gpio[n_lines]  = gpio_v;
          n_lines++;
        end
      end
      $fclose(fd);
      if (n_lines == 0) begin
        $display("ERROR: trace file holds no transfers");
        err_cnt++;
      end
    end
  endtask

  // data-phase wait states per slave and direction
  function automatic int expected_waits(logic write, logic [31:0] addr);
    if (addr[31:28] == 4'h0) begin
      return write ? 0 : 1;
    end
    if (addr[31:28] == 4'hB) begin
      return 0;
    end
    return 1;
  endfunction

  task automatic retire_transfer(int idx, int waits);
    int exp_waits;
    exp_waits = expected_waits(tr_write[idx], tr_addr[idx]);
    check_cnt++;
    if (seen_resp !== tr_resp[idx]) begin
      $display("FAILED %0t o_hresp expected %0d got %0d", $time, tr_resp[idx], seen_resp);
      err_cnt++;
    end
    if (!tr_write[idx]) begin
      check_cnt++;
      if (seen_rdata !== tr_data[idx]) begin
        $display("FAILED %0t o_hrdata expected %h got %h", $time, tr_data[idx], seen_rdata);
        err_cnt++;
      end
    end
    check_cnt++;
    if (waits != exp_waits) begin
      $display("FAILED %0t o_hready wait cycles expected %0d got %0d", $time, exp_waits, waits);
      err_cnt++;
    end
    // output register sits at index 0 of region 0xB
    if (tr_write[idx] && tr_addr[idx][31:28] == 4'hB && tr_addr[idx][27:2] == '0) begin
      gpio_pend = 1'b1;
      gpio_exp  = tr_data[idx][GPIO_W-1:0];
    end
  endtask

  task automatic advance_pipeline;
    d_valid  = a_valid;
    d_idx    = a_idx;
    d_waits  = 0;
    i_hwdata = (a_valid && tr_write[a_idx]) ? tr_data[a_idx] : '0;
    if (next_line < n_lines && gap_left == 0) begin
      a_valid      = 1'b1;
      a_idx        = next_line;
      i_haddr      = tr_addr[next_line];
      i_htrans     = 2'b10;
      i_hwrite     = tr_write[next_line];
      i_gpio_porta = tr_gpio[next_line];
      gap_left     = $urandom % 3;
      next_line++;
    end else begin
      a_valid  = 1'b0;
      i_haddr  = '0;
      i_htrans = 2'b00;
      i_hwrite = 1'b0;
      if (gap_left > 0) begin
        gap_left--;
      end
    end
  endtask

  initial begin
    err_cnt      = 0;
    check_cnt    = 0;
    trace_loaded = 1'b0;
    i_arst_n     = 1'b0;
    i_haddr      = '0;
    i_htrans     = 2'b00;
    i_hwrite     = 1'b0;
    i_hwdata     = '0;
    i_gpio_porta = '0;
    a_valid      = 1'b0;
    d_valid      = 1'b0;
    a_idx        = 0;
    d_idx        = 0;
    d_waits      = 0;
    next_line    = 0;
    gpio_pend    = 1'b0;
    gpio_exp     = '0;
    gap_left     = $urandom(48740) % 3;
    load_trace();
    trace_loaded = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    check_cnt++;
    if (o_hready !== 1'b1 || o_hresp !== 1'b0 || o_gpio_porta !== '0) begin
      $display("FAILED %0t reset state o_hready/o_hresp/o_gpio_porta expected 1/0/00 got %b/%b/%h",
               $time, o_hready, o_hresp, o_gpio_porta);
      err_cnt++;
    end
    seen_ready = o_hready;
    seen_resp  = o_hresp;
    seen_rdata = o_hrdata;
    while (next_line < n_lines || a_valid || d_valid || gpio_pend) begin
      @(negedge clk);
      if (gpio_pend) begin
        check_cnt++;
        if (o_gpio_porta !== gpio_exp) begin
          $display("FAILED %0t o_gpio_porta expected %h got %h", $time, gpio_exp, o_gpio_porta);
          err_cnt++;
        end
        gpio_pend = 1'b0;
      end
      if (seen_ready) begin
        if (d_valid) begin
          retire_transfer(d_idx, d_waits);
        end
        advance_pipeline();
      end else if (d_valid) begin
        d_waits++;
      end
      // outputs hold from here to the next rising edge
      seen_ready = o_hready;
      seen_resp  = o_hresp;
      seen_rdata = o_hrdata;
    end
    $display("errors: %0d  checks: %0d", err_cnt, check_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    wait (trace_loaded);
    #((n_lines * 6 + RESET_CYCLES + 100) * CLK_PERIOD);
    $display("ERROR: watchdog expired before the trace finished");
    err_cnt++;
    $display("errors: %0d  checks: %0d", err_cnt, check_cnt);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* test/ahb_sub_trace.txt */
# op addr data resp gpio_in (hex except resp, 0 OKAY 1 ERROR)
# W data is written, R data is the expected read value
W 00000000 11223344 0 5A
W 00000004 A5A5F00F 0 5A
R 00000000 11223344 0 5A
R 00000004 A5A5F00F 0 5A
W 00000010 CAFEBABE 0 5A
R 00000010 CAFEBABE 0 5A
W 00000010 0BADF00D 0 5A
R 00000010 0BADF00D 0 5A
W 000003FC 89ABCDEF 0 5A
W 00000400 13579BDF 0 5A
R 000003FC 89ABCDEF 0 5A
R 00000000 13579BDF 0 5A
W B0000000 000012C3 0 5A
R B0000000 000000C3 0 5A
R B0000004 0000005A 0 5A
W B0000004 FFFFFFFF 0 3C
R B0000008 00000000 0 3C
R B0000004 0000003C 0 3C
W B0000000 000000A5 0 3C
R B0000000 000000A5 0 3C
W 50000010 DEADBEEF 1 3C
R 00000010 0BADF00D 0 3C
R F0000000 00000000 1 3C
W 20000000 00000001 1 3C
R 00000004 A5A5F00F 0 3C

/* verilog/ahb_decoder.sv */
// AHB address decoder and response mux
`timescale 1ns/1ps

module ahb_decoder (
  input  logic                            i_per_clk,
  input  logic                            i_arst_n,
  input  ahb_sub_pkg::haddr_t             i_haddr,
  input  logic [1:0]                      i_htrans,
  input  logic                            i_hwrite,
  input  logic [ahb_sub_pkg::DATA_W-1:0]  i_hwdata,
  output logic [ahb_sub_pkg::DATA_W-1:0]  o_hrdata,
  output logic                            o_hready,
  output logic                            o_hresp,
  ahb_if.master                           mem_bus,
  ahb_if.master                           gpio_bus,
  ahb_if.master                           err_bus
);
  import ahb_sub_pkg::*;

  logic       nonseq;
  slave_sel_t addr_sel;
  slave_sel_t data_sel;

  assign nonseq = (i_htrans == HTRANS_NONSEQ);

  always_comb begin
    case (i_haddr.fields.region)
      REGION_MEM:  addr_sel = SEL_MEM;
      REGION_GPIO: addr_sel = SEL_GPIO;
      default:     addr_sel = SEL_ERR;
    endcase
  end

  assign mem_bus.hsel  = nonseq && (addr_sel == SEL_MEM);
  assign gpio_bus.hsel = nonseq && (addr_sel == SEL_GPIO);
  assign err_bus.hsel  = nonseq && (addr_sel == SEL_ERR);

  // address, write and data go to everyone
  assign mem_bus.haddr   = i_haddr;
  assign mem_bus.hwrite  = i_hwrite;
  assign mem_bus.hwdata  = i_hwdata;
  assign mem_bus.hready  = o_hready;
  assign gpio_bus.haddr  = i_haddr;
  assign gpio_bus.hwrite = i_hwrite;
  assign gpio_bus.hwdata = i_hwdata;
  assign gpio_bus.hready = o_hready;
  assign err_bus.haddr   = i_haddr;
  assign err_bus.hwrite  = i_hwrite;
  assign err_bus.hwdata  = i_hwdata;
  assign err_bus.hready  = o_hready;

  // owner of the data phase, idle clears it
  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      data_sel <= SEL_NONE;
    end else if (o_hready) begin
      data_sel <= nonseq ? addr_sel : SEL_NONE;
    end
  end

  always_comb begin
    case (data_sel)
      SEL_MEM: begin
        o_hrdata = mem_bus.hrdata;
        o_hready = mem_bus.hready_out;
        o_hresp  = mem_bus.hresp;
      end
      SEL_GPIO: begin
        o_hrdata = gpio_bus.hrdata;
        o_hready = gpio_bus.hready_out;
        o_hresp  = gpio_bus.hresp;
      end
      SEL_ERR: begin
        o_hrdata = err_bus.hrdata;
        o_hready = err_bus.hready_out;
        o_hresp  = err_bus.hresp;
      end
      default: begin
        o_hrdata = '0;
        o_hready = 1'b1;
        o_hresp  = HRESP_OKAY;
      end
    endcase
  end

  // slaves outside the data phase stay ready and quiet
  a_idle_slaves: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    (data_sel == SEL_MEM  || (mem_bus.hready_out && mem_bus.hresp == HRESP_OKAY)) &&
    (data_sel == SEL_GPIO || (gpio_bus.hready_out && gpio_bus.hresp == HRESP_OKAY)) &&
    (data_sel == SEL_ERR  || (err_bus.hready_out && err_bus.hresp == HRESP_OKAY)));

endmodule

/* verilog/ahb_err_gen.sv */
// error responder for unmapped regions
`timescale 1ns/1ps

module ahb_err_gen (
  input  logic  i_per_clk,
  input  logic  i_arst_n,
  ahb_if.slave  bus
);
  import ahb_sub_pkg::*;

  logic err_first;
  logic err_second;

  // two-cycle ERROR, writes are simply dropped
  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      err_first  <= 1'b0;
      err_second <= 1'b0;
    end else begin
      err_first  <= bus.hsel && bus.hready;
      err_second <= err_first;
    end
  end

  assign bus.hrdata     = '0;
  assign bus.hready_out = !err_first;
  assign bus.hresp      = (err_first || err_second) ? HRESP_ERROR : HRESP_OKAY;

  a_err_pair: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    (bus.hresp == HRESP_ERROR && !bus.hready_out)
      |=> (bus.hresp == HRESP_ERROR && bus.hready_out));

endmodule

/* verilog/ahb_gpio_regs.sv */
// GPIO register slave
`timescale 1ns/1ps

module ahb_gpio_regs #(
  parameter int GPIO_W = 8
) (
  input  logic              i_per_clk,
  input  logic              i_arst_n,
  ahb_if.slave              bus,
  input  logic [GPIO_W-1:0] i_gpio_porta,
  output logic [GPIO_W-1:0] o_gpio_porta
);
  import ahb_sub_pkg::*;

  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] in_q;
  logic              wr_q;
  logic              out_sel_q;
  logic              in_sel_q;

  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_q      <= 1'b0;
      out_sel_q <= 1'b0;
      in_sel_q  <= 1'b0;
    end else if (bus.hready) begin
      wr_q      <= bus.hsel && bus.hwrite;
      out_sel_q <= bus.hsel && (bus.haddr.fields.index == '0);
      in_sel_q  <= bus.hsel && (bus.haddr.fields.index == 26'd1);
    end
  end

  // input port sampled every cycle
  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_q <= '0;
      in_q  <= '0;
    end else begin
      in_q <= i_gpio_porta;
      if (bus.hready && wr_q && out_sel_q) begin
        out_q <= bus.hwdata[GPIO_W-1:0];
      end
    end
  end

  assign bus.hrdata = out_sel_q ? DATA_W'(out_q) :
                      in_sel_q  ? DATA_W'(in_q)  : '0;
  assign bus.hready_out = 1'b1;
  assign bus.hresp      = HRESP_OKAY;
  assign o_gpio_porta   = out_q;

endmodule

/* verilog/ahb_if.sv */
// decoder to slave AHB link
`timescale 1ns/1ps

interface ahb_if;
  import ahb_sub_pkg::*;

  haddr_t            haddr;
  logic              hwrite;
  logic [DATA_W-1:0] hwdata;
  logic              hsel;
  // global ready, same on every slave
  logic              hready;

  logic [DATA_W-1:0] hrdata;
  logic              hready_out;
  logic              hresp;

  modport master (
    output haddr, hwrite, hwdata, hsel, hready,
    input  hrdata, hready_out, hresp
  );

  modport slave (
    input  haddr, hwrite, hwdata, hsel, hready,
    output hrdata, hready_out, hresp
  );

endinterface

/* verilog/ahb_mem_ctrl.sv */
// word SRAM slave, one read wait state
`timescale 1ns/1ps

module ahb_mem_ctrl #(
  parameter int MEM_WORDS = 256
) (
  input  logic  i_per_clk,
  input  logic  i_arst_n,
  ahb_if.slave  bus
);
  import ahb_sub_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic [IDX_W-1:0]  idx_q;
  logic [DATA_W-1:0] rdata_q;
  logic              wr_q;
  logic              rd_wait;

  // data phase state, advances only when the bus moves
  always_ff @(posedge i_per_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_q    <= 1'b0;
      rd_wait <= 1'b0;
    end else if (bus.hready) begin
      wr_q    <= bus.hsel && bus.hwrite;
      rd_wait <= bus.hsel && !bus.hwrite;
    end else begin
      rd_wait <= 1'b0;
    end
  end

  always_ff @(posedge i_per_clk) begin
    if (bus.hready && bus.hsel) begin
      idx_q <= IDX_W'(bus.haddr.fields.index % MEM_WORDS);
    end
  end

  // write lands at the end of its data phase
  always_ff @(posedge i_per_clk) begin
    if (wr_q && bus.hready) begin
      mem[idx_q] <= bus.hwdata;
    end
  end

  always_ff @(posedge i_per_clk) begin
    if (rd_wait) begin
      rdata_q <= mem[idx_q];
    end
  end

  assign bus.hrdata     = rdata_q;
  assign bus.hready_out = !rd_wait;
  assign bus.hresp      = HRESP_OKAY;

  a_single_wait: assert property (@(posedge i_per_clk) disable iff (!i_arst_n)
    !bus.hready_out |=> bus.hready_out);

endmodule

/* verilog/ahb_sub_pkg.sv */
// AHB subsystem shared definitions

package ahb_sub_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // only single full-word transfers
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // top nibble of the address picks the slave
  localparam logic [3:0] REGION_MEM  = 4'h0;
  localparam logic [3:0] REGION_GPIO = 4'hB;

  typedef struct packed {
    logic [3:0]  region;
    logic [25:0] index;
    logic [1:0]  offset;
  } haddr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    haddr_fields_t     fields;
  } haddr_t;

  // data-phase owner, none after reset or idle
  typedef enum logic [1:0] {
    SEL_NONE = 2'd0,
    SEL_MEM  = 2'd1,
    SEL_GPIO = 2'd2,
    SEL_ERR  = 2'd3
  } slave_sel_t;

endpackage

/* verilog/ahb_sub_top.sv */
// AHB subsystem top
`timescale 1ns/1ps

module ahb_sub_top #(
  parameter int MEM_WORDS = 256,
  parameter int GPIO_W    = 8
) (
  input  logic                            i_per_clk,
  input  logic                            i_arst_n,
  input  logic [ahb_sub_pkg::ADDR_W-1:0]  i_haddr,
  input  logic [1:0]                      i_htrans,
  input  logic                            i_hwrite,
  input  logic [ahb_sub_pkg::DATA_W-1:0]  i_hwdata,
  output logic [ahb_sub_pkg::DATA_W-1:0]  o_hrdata,
  output logic                            o_hready,
  output logic                            o_hresp,
  input  logic [GPIO_W-1:0]               i_gpio_porta,
  output logic [GPIO_W-1:0]               o_gpio_porta
);

  ahb_if mem_bus ();
  ahb_if gpio_bus ();
  ahb_if err_bus ();

  ahb_decoder u_decoder (
    .i_per_clk (i_per_clk),
    .i_arst_n  (i_arst_n),
    .i_haddr   (i_haddr),
    .i_htrans  (i_htrans),
    .i_hwrite  (i_hwrite),
    .i_hwdata  (i_hwdata),
    .o_hrdata  (o_hrdata),
    .o_hready  (o_hready),
    .o_hresp   (o_hresp),
    .mem_bus   (mem_bus.master),
    .gpio_bus  (gpio_bus.master),
    .err_bus   (err_bus.master)
  );

  ahb_mem_ctrl #(.MEM_WORDS(MEM_WORDS)) u_mem_ctrl (
    .i_per_clk (i_per_clk),
    .i_arst_n  (i_arst_n),
    .bus       (mem_bus.slave)
  );

  ahb_gpio_regs #(.GPIO_W(GPIO_W)) u_gpio_regs (
    .i_per_clk    (i_per_clk),
    .i_arst_n     (i_arst_n),
    .bus          (gpio_bus.slave),
    .i_gpio_porta (i_gpio_porta),
    .o_gpio_porta (o_gpio_porta)
  );

  ahb_err_gen u_err_gen (
    .i_per_clk (i_per_clk),
    .i_arst_n  (i_arst_n),
    .bus       (err_bus.slave)
  );

endmodule
